/* design/dcache_pkg.sv */
////////////////////
// dcache shared types
// address split, request and memory command structs, FSM and opcode enums
////////////////////
package dcache_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [22:0] tag_t;
  typedef logic [5:0]  index_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY = 2'd0;
  localparam int    NUM_SETS  = 64;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } cache_op_e;

  typedef enum logic {
    MEM_FILL,
    MEM_WRITEBACK
  } mem_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WB,
    ST_FILL,
    ST_RESP
  } ctrl_state_e;

  typedef struct packed {
    cache_op_e op;
    addr_t     addr;
    data_t     wdata;
    strb_t     strb;
  } cache_req_t;

  typedef struct packed {
    mem_op_e op;
    addr_t   addr;   // line aligned
    data_t   data;
  } mem_cmd_t;

  typedef struct packed {
    cache_op_e op;
    data_t     rdata;
  } cache_resp_t;

  // | tag 31:9 | index 8:3 | offset 2:0 |
  function automatic tag_t addr_tag(input addr_t a);
    return a[31:9];
  endfunction

  function automatic index_t addr_index(input addr_t a);
    return a[8:3];
  endfunction

endpackage

/* design/dcache_data_ram.sv */
////////////////////
// dcache data RAM
// one way of line storage, single port,
// byte write enables, registered read
////////////////////
module dcache_data_ram
  import dcache_pkg::*;
#(
  parameter int NUM_WORDS = 64
) (
  input  logic   clk,
  input  logic   en_i,
  input  logic   we_i,
  input  strb_t  strb_i,
  input  index_t addr_i,
  input  data_t  wdata_i,
  output data_t  rdata_o
);

  data_t mem_q [NUM_WORDS];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < 8; b++) begin
          if (strb_i[b]) mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem_q[addr_i];  // old data on a write cycle
    end
  end

endmodule

/* design/dcache_core_port.sv */
////////////////////
// dcache core port
// takes one read or write from the core at a time,
// hands it to the controller and returns the r or b response
////////////////////
module dcache_core_port
  import dcache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        ar_valid_i,
  output logic        ar_ready_o,
  input  addr_t       ar_addr_i,
  output logic        r_valid_o,
  input  logic        r_ready_i,
  output data_t       r_data_o,
  output resp_t       r_resp_o,
  input  logic        aw_valid_i,
  output logic        aw_ready_o,
  input  addr_t       aw_addr_i,
  input  logic        w_valid_i,
  output logic        w_ready_o,
  input  data_t       w_data_i,
  input  strb_t       w_strb_i,
  output logic        b_valid_o,
  input  logic        b_ready_i,
  output resp_t       b_resp_o,
  output logic        req_valid_o,
  input  logic        req_take_i,
  output cache_req_t  req_o,
  input  logic        resp_valid_i,
  input  cache_resp_t resp_i
);

  logic       busy_q;     // request outstanding until r/b handshake
  logic       req_valid_q;
  logic       aw_got_q;
  logic       w_got_q;
  logic       r_valid_q;
  logic       b_valid_q;
  cache_req_t req_q;
  addr_t      aw_addr_q;
  data_t      w_data_q;
  strb_t      w_strb_q;
  data_t      r_data_q;

  logic ar_hs, aw_hs, w_hs, write_fire;

  assign ar_ready_o = !busy_q && !aw_got_q && !w_got_q;
  assign aw_ready_o = !busy_q && !aw_got_q && !(ar_valid_i && ar_ready_o);  // read wins
  assign w_ready_o  = !busy_q && !w_got_q;

  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign w_hs       = w_valid_i && w_ready_o;
  assign write_fire = !busy_q && (aw_got_q || aw_hs) && (w_got_q || w_hs);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      req_valid_q <= 1'b0;
      aw_got_q    <= 1'b0;
      w_got_q     <= 1'b0;
      r_valid_q   <= 1'b0;
      b_valid_q   <= 1'b0;
    end else begin
      if (ar_hs || write_fire) begin
        busy_q      <= 1'b1;
        req_valid_q <= 1'b1;
      end else if (req_take_i) begin
        req_valid_q <= 1'b0;
      end
      if (write_fire) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end else begin
        if (aw_hs) aw_got_q <= 1'b1;
        if (w_hs)  w_got_q  <= 1'b1;
      end
      if (resp_valid_i && resp_i.op == OP_READ) r_valid_q <= 1'b1;
      if (resp_valid_i && resp_i.op == OP_WRITE) b_valid_q <= 1'b1;
      if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
        busy_q    <= 1'b0;
      end
      if (b_valid_q && b_ready_i) begin
        b_valid_q <= 1'b0;
        busy_q    <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) aw_addr_q <= aw_addr_i;
    if (w_hs) begin
      w_data_q <= w_data_i;
      w_strb_q <= w_strb_i;
    end
    if (ar_hs) begin
      req_q <= '{op: OP_READ, addr: ar_addr_i, wdata: '0, strb: '0};
    end else if (write_fire) begin
      req_q.op    <= OP_WRITE;
      req_q.addr  <= aw_hs ? aw_addr_i : aw_addr_q;
      req_q.wdata <= w_hs ? w_data_i : w_data_q;
      req_q.strb  <= w_hs ? w_strb_i : w_strb_q;
    end
    if (resp_valid_i) r_data_q <= resp_i.rdata;
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;
  assign r_valid_o   = r_valid_q;
  assign r_data_o    = r_data_q;
  assign r_resp_o    = RESP_OKAY;
  assign b_valid_o   = b_valid_q;
  assign b_resp_o    = RESP_OKAY;

  // controller answers only a request already taken from this port
  a_resp_outstanding: assert property (@(posedge clk) disable iff (rst)
    resp_valid_i |-> busy_q && !req_valid_q);

endmodule

/* design/dcache_ctrl.sv */
////////////////////
// dcache controller
// tag lookup, victim choice, writeback and fill FSM
// owns tag/valid/dirty arrays and the per-way data RAMs
////////////////////
module dcache_ctrl
  import dcache_pkg::*;
#(
  parameter int NUM_WAYS = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid_i,
  output logic        req_take_o,
  input  cache_req_t  req_i,
  output logic        resp_valid_o,
  output cache_resp_t resp_o,
  output logic        cmd_valid_o,
  output mem_cmd_t    cmd_o,
  input  logic        cmd_done_i,
  input  data_t       fill_data_i
);

  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  ctrl_state_e state_q;
  cache_req_t  req_q;
  logic        cmd_valid_q;
  mem_cmd_t    cmd_q;
  data_t       rdata_q;
  logic [WAY_W-1:0] victim_q;  // free running
  logic [WAY_W-1:0] way_q;

  tag_t tag_q [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;

  index_t idx;
  tag_t   req_tag;
  logic [NUM_WAYS-1:0] hit_vec;
  logic [WAY_W-1:0]    hit_way;
  data_t  fill_line;

  logic [NUM_WAYS-1:0] ram_en;
  logic [NUM_WAYS-1:0] ram_we;
  index_t ram_addr;
  strb_t  ram_strb;
  data_t  ram_wdata;
  data_t  ram_rdata [NUM_WAYS];

  assign idx     = addr_index(req_q.addr);
  assign req_tag = addr_tag(req_q.addr);

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = valid_q[w][idx] && (tag_q[w][idx] == req_tag);
      if (hit_vec[w]) hit_way = WAY_W'(w);
    end
  end

  // write miss merges its bytes into the incoming line
  always_comb begin
    fill_line = fill_data_i;
    for (int b = 0; b < 8; b++) begin
      if (req_q.op == OP_WRITE && req_q.strb[b]) fill_line[8*b +: 8] = req_q.wdata[8*b +: 8];
    end
  end

  assign ram_addr  = (state_q == ST_IDLE) ? addr_index(req_i.addr) : idx;
  assign ram_strb  = (state_q == ST_FILL) ? '1 : req_q.strb;
  assign ram_wdata = (state_q == ST_FILL) ? fill_line : req_q.wdata;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    assign ram_we[w] = (state_q == ST_LOOKUP && hit_vec[w] && req_q.op == OP_WRITE) ||
                       (state_q == ST_FILL && cmd_done_i && way_q == WAY_W'(w));
    assign ram_en[w] = (state_q == ST_IDLE && req_valid_i) || ram_we[w];

    dcache_data_ram #(
      .NUM_WORDS (NUM_SETS)
    ) i_data_ram (
      .clk     (clk),
      .en_i    (ram_en[w]),
      .we_i    (ram_we[w]),
      .strb_i  (ram_strb),
      .addr_i  (ram_addr),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata[w])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_IDLE;
      cmd_valid_q <= 1'b0;
      valid_q     <= '0;
      dirty_q     <= '0;
      victim_q    <= '0;
    end else begin
      victim_q <= (victim_q == WAY_W'(NUM_WAYS - 1)) ? '0 : victim_q + 1'b1;
      case (state_q)
        ST_IDLE: if (req_valid_i) state_q <= ST_LOOKUP;
        ST_LOOKUP: begin
          cmd_valid_q <= !(|hit_vec);
          if (|hit_vec) begin
            if (req_q.op == OP_WRITE) dirty_q[hit_way][idx] <= 1'b1;
            state_q <= ST_RESP;
          end else if (dirty_q[victim_q][idx]) begin
            state_q <= ST_WB;
          end else begin
            state_q <= ST_FILL;
          end
        end
        ST_WB: if (cmd_done_i) state_q <= ST_FILL;  // cmd stays valid, now a fill
        ST_FILL: begin
          if (cmd_done_i) begin
            cmd_valid_q          <= 1'b0;
            valid_q[way_q][idx]  <= 1'b1;
            dirty_q[way_q][idx]  <= (req_q.op == OP_WRITE);
            state_q              <= ST_RESP;
          end
        end
        ST_RESP: state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_take_o) req_q <= req_i;
    if (state_q == ST_LOOKUP) begin
      way_q   <= (|hit_vec) ? hit_way : victim_q;
      rdata_q <= ram_rdata[hit_way];
      if (dirty_q[victim_q][idx]) begin
        // evicted line goes out under its old tag
        cmd_q <= '{op: MEM_WRITEBACK, addr: {tag_q[victim_q][idx], idx, 3'b000},
                   data: ram_rdata[victim_q]};
      end else begin
        cmd_q <= '{op: MEM_FILL, addr: {req_tag, idx, 3'b000}, data: '0};
      end
    end
    if (state_q == ST_WB && cmd_done_i) begin
      cmd_q <= '{op: MEM_FILL, addr: {req_tag, idx, 3'b000}, data: '0};
    end
    if (state_q == ST_FILL && cmd_done_i) begin
      tag_q[way_q][idx] <= req_tag;
      rdata_q           <= fill_data_i;
    end
  end

  assign req_take_o   = (state_q == ST_IDLE) && req_valid_i;
  assign resp_valid_o = (state_q == ST_RESP);
  assign resp_o       = '{op: req_q.op, rdata: rdata_q};
  assign cmd_valid_o  = cmd_valid_q;
  assign cmd_o        = cmd_q;

  a_one_hit: assert property (@(posedge clk) disable iff (rst)
    (state_q == ST_LOOKUP) |-> $onehot0(hit_vec));

  // memory port relies on a steady command until done
  a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
    cmd_valid_o && !cmd_done_i |=> cmd_valid_o && $stable(cmd_o));

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state_q inside {ST_IDLE, ST_LOOKUP, ST_WB, ST_FILL, ST_RESP});

endmodule

/* design/dcache_mem_port.sv */
////////////////////
// dcache memory port
// bus master, one line fill or one line writeback per command
////////////////////
module dcache_mem_port
  import dcache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     cmd_valid_i,
  input  mem_cmd_t cmd_i,
  output logic     cmd_done_o,
  output data_t    fill_data_o,
  output logic     mem_ar_valid_o,
  input  logic     mem_ar_ready_i,
  output addr_t    mem_ar_addr_o,
  input  logic     mem_r_valid_i,
  output logic     mem_r_ready_o,
  input  data_t    mem_r_data_i,
  output logic     mem_aw_valid_o,
  input  logic     mem_aw_ready_i,
  output addr_t    mem_aw_addr_o,
  output logic     mem_w_valid_o,
  input  logic     mem_w_ready_i,
  output data_t    mem_w_data_o,
  output strb_t    mem_w_strb_o,
  input  logic     mem_b_valid_i,
  output logic     mem_b_ready_o
);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_AR,
    PH_R,
    PH_AW,
    PH_W,
    PH_B,
    PH_DONE
  } phase_e;

  phase_e phase_q;
  data_t  fill_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q <= PH_IDLE;
    end else begin
      case (phase_q)
        PH_IDLE: if (cmd_valid_i) phase_q <= (cmd_i.op == MEM_FILL) ? PH_AR : PH_AW;
        PH_AR:   if (mem_ar_ready_i) phase_q <= PH_R;
        PH_R:    if (mem_r_valid_i) phase_q <= PH_DONE;
        PH_AW:   if (mem_aw_ready_i) phase_q <= PH_W;
        PH_W:    if (mem_w_ready_i) phase_q <= PH_B;
        PH_B:    if (mem_b_valid_i) phase_q <= PH_DONE;
        default: phase_q <= PH_IDLE;  // PH_DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase_q == PH_R && mem_r_valid_i) fill_q <= mem_r_data_i;
  end

  assign cmd_done_o     = (phase_q == PH_DONE);
  assign fill_data_o    = fill_q;

  // addr and data come straight from the held command
  assign mem_ar_valid_o = (phase_q == PH_AR);
  assign mem_ar_addr_o  = cmd_i.addr;
  assign mem_r_ready_o  = (phase_q == PH_R);
  assign mem_aw_valid_o = (phase_q == PH_AW);
  assign mem_aw_addr_o  = cmd_i.addr;
  assign mem_w_valid_o  = (phase_q == PH_W);
  assign mem_w_data_o   = cmd_i.data;
  assign mem_w_strb_o   = '1;  // full line
  assign mem_b_ready_o  = (phase_q == PH_B);

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o));
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o && $stable(mem_aw_addr_o));
  a_w_hold: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid_o && !mem_w_ready_i |=> mem_w_valid_o && $stable(mem_w_data_o));

endmodule

/* design/dcache_top.sv */
////////////////////
// dcache top
// core port, controller and memory port
////////////////////
module dcache_top
  import dcache_pkg::*;
#(
  parameter int NUM_WAYS = 2
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  addr_t ar_addr_i,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output data_t r_data_o,
  output resp_t r_resp_o,
  input  logic  aw_valid_i,
  output logic  aw_ready_o,
  input  addr_t aw_addr_i,
  input  logic  w_valid_i,
  output logic  w_ready_o,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  output logic  b_valid_o,
  input  logic  b_ready_i,
  output resp_t b_resp_o,
  output logic  mem_ar_valid_o,
  input  logic  mem_ar_ready_i,
  output addr_t mem_ar_addr_o,
  input  logic  mem_r_valid_i,
  output logic  mem_r_ready_o,
  input  data_t mem_r_data_i,
  output logic  mem_aw_valid_o,
  input  logic  mem_aw_ready_i,
  output addr_t mem_aw_addr_o,
  output logic  mem_w_valid_o,
  input  logic  mem_w_ready_i,
  output data_t mem_w_data_o,
  output strb_t mem_w_strb_o,
  input  logic  mem_b_valid_i,
  output logic  mem_b_ready_o
);

  logic        req_valid, req_take, resp_valid, cmd_valid, cmd_done;
  cache_req_t  req;
  cache_resp_t resp;
  mem_cmd_t    cmd;
  data_t       fill_data;

  dcache_core_port i_core_port (
    .clk, .rst,
    .ar_valid_i, .ar_ready_o, .ar_addr_i,
    .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o,
    .aw_valid_i, .aw_ready_o, .aw_addr_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .b_valid_o, .b_ready_i, .b_resp_o,
    .req_valid_o  (req_valid),
    .req_take_i   (req_take),
    .req_o        (req),
    .resp_valid_i (resp_valid),
    .resp_i       (resp)
  );

  dcache_ctrl #(
    .NUM_WAYS (NUM_WAYS)
  ) i_ctrl (
    .clk, .rst,
    .req_valid_i  (req_valid),
    .req_take_o   (req_take),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd),
    .cmd_done_i   (cmd_done),
    .fill_data_i  (fill_data)
  );

  dcache_mem_port i_mem_port (
    .clk, .rst,
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .cmd_done_o   (cmd_done),
    .fill_data_o  (fill_data),
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o,
    .mem_r_valid_i, .mem_r_ready_o, .mem_r_data_i,
    .mem_aw_valid_o, .mem_aw_ready_i, .mem_aw_addr_o,
    .mem_w_valid_o, .mem_w_ready_i, .mem_w_data_o, .mem_w_strb_o,
    .mem_b_valid_i, .mem_b_ready_o
  );

endmodule

/* tests/tb_mem_slave.sv */
////////////////////
// memory bus slave model
// sparse line memory with address-derived contents,
// random ready and valid delays on every channel
////////////////////
module tb_mem_slave
  import dcache_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  addr_t ar_addr_i,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output data_t r_data_o,
  input  logic  aw_valid_i,
  output logic  aw_ready_o,
  input  addr_t aw_addr_i,
  input  logic  w_valid_i,
  output logic  w_ready_o,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  output logic  b_valid_o,
  input  logic  b_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  data_t mem [addr_t];

  logic  ar_ready_q = 1'b0;
  logic  r_valid_q  = 1'b0;
  logic  aw_ready_q = 1'b0;
  logic  w_ready_q  = 1'b0;
  logic  b_valid_q  = 1'b0;
  logic  rd_pend_q  = 1'b0;
  logic  b_pend_q   = 1'b0;
  data_t r_data_q   = '0;
  addr_t rd_addr_q;
  addr_t wr_addr_q;

  // untouched lines read as a mix of their own address
  function automatic data_t line_init(input addr_t a);
    return {a ^ 32'h3c6e_f372, {a[15:0], a[31:16]} ^ 32'ha54f_f53a};
  endfunction

  function automatic data_t line_read(input addr_t a);
    if (mem.exists(a)) return mem[a];
    return line_init(a);
  endfunction

  function automatic data_t strobe_merge(input data_t old, input data_t nw, input strb_t s);
    data_t res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (s[b]) res[8*b +: 8] = nw[8*b +: 8];
    end
    return res;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      aw_ready_q <= 1'b0;
      w_ready_q  <= 1'b0;
      b_valid_q  <= 1'b0;
      rd_pend_q  <= 1'b0;
      b_pend_q   <= 1'b0;
    end else begin
      if (ar_valid_i && ar_ready_q) begin
        rd_addr_q  <= {ar_addr_i[31:3], 3'b000};
        rd_pend_q  <= 1'b1;
        ar_ready_q <= 1'b0;
      end else begin
        ar_ready_q <= ($urandom_range(0, 2) != 0);
      end
      if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
      end else if (rd_pend_q && !r_valid_q && $urandom_range(0, 2) == 0) begin
        r_valid_q <= 1'b1;
        r_data_q  <= line_read(rd_addr_q);
        rd_pend_q <= 1'b0;
      end
      if (aw_valid_i && aw_ready_q) begin
        wr_addr_q  <= {aw_addr_i[31:3], 3'b000};
        aw_ready_q <= 1'b0;
      end else begin
        aw_ready_q <= ($urandom_range(0, 2) != 0);
      end
      if (w_valid_i && w_ready_q) begin
        mem[wr_addr_q] = strobe_merge(line_read(wr_addr_q), w_data_i, w_strb_i);
        b_pend_q  <= 1'b1;
        w_ready_q <= 1'b0;
      end else begin
        w_ready_q <= ($urandom_range(0, 2) != 0);
      end
      if (b_valid_q && b_ready_i) begin
        b_valid_q <= 1'b0;
      end else if (b_pend_q && !b_valid_q && $urandom_range(0, 2) == 0) begin
        b_valid_q <= 1'b1;
        b_pend_q  <= 1'b0;
      end
    end
  end

  assign ar_ready_o = ar_ready_q;
  assign r_valid_o  = r_valid_q;
  assign r_data_o   = r_data_q;
  assign aw_ready_o = aw_ready_q;
  assign w_ready_o  = w_ready_q;
  assign b_valid_o  = b_valid_q;

endmodule

/* tests/tb_dcache.sv */
////////////////////
// dcache testbench
// random reads and strobed writes over an aliasing address pool,
// golden memory model, writeback monitor, final read-back sweep
////////////////////
module tb_dcache
  import dcache_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REQS = 400;
  localparam int POOL     = 12;   // 3 sets x 4 tags
  localparam int TIMEOUT_CYCLES = (NUM_REQS + POOL) * 200;

  logic  clk, rst;
  logic  ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  addr_t ar_addr_i;
  data_t r_data_o;
  resp_t r_resp_o;
  logic  aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  addr_t aw_addr_i;
  data_t w_data_i;
  strb_t w_strb_i;
  resp_t b_resp_o;
  logic  mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  addr_t mem_ar_addr_o;
  data_t mem_r_data_i;
  logic  mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  addr_t mem_aw_addr_o;
  data_t mem_w_data_o;
  strb_t mem_w_strb_o;
  logic  mem_b_valid_i, mem_b_ready_o;

  int    n_checks;
  int    n_errors;
  addr_t pool [POOL];
  data_t gold [addr_t];
  addr_t cur_line;
  addr_t wb_addr;

  dcache_top #(
    .NUM_WAYS (2)
  ) i_dcache_top (.*);

  tb_mem_slave i_mem (
    .clk, .rst,
    .ar_valid_i (mem_ar_valid_o), .ar_ready_o (mem_ar_ready_i), .ar_addr_i (mem_ar_addr_o),
    .r_valid_o  (mem_r_valid_i),  .r_ready_i  (mem_r_ready_o),  .r_data_o  (mem_r_data_i),
    .aw_valid_i (mem_aw_valid_o), .aw_ready_o (mem_aw_ready_i), .aw_addr_i (mem_aw_addr_o),
    .w_valid_i  (mem_w_valid_o),  .w_ready_o  (mem_w_ready_i),  .w_data_i  (mem_w_data_o),
    .w_strb_i   (mem_w_strb_o),
    .b_valid_o  (mem_b_valid_i),  .b_ready_i  (mem_b_ready_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // memory contents before any write, fixed per address
  function automatic data_t init_value(input addr_t a);
    return {a ^ 32'h3c6e_f372, {a[15:0], a[31:16]} ^ 32'ha54f_f53a};
  endfunction

  function automatic data_t gold_line(input addr_t a);
    addr_t key;
    key = {a[31:3], 3'b000};
    if (gold.exists(key)) return gold[key];
    return init_value(key);
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
    data_t res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (s[b]) res[8*b +: 8] = nw[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input strb_t got, input strb_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  // fills target the line in flight and writebacks carry golden data
  always @(negedge clk) begin
    if (!rst) begin
      if (mem_ar_valid_o && mem_ar_ready_i) check_addr("mem_ar_addr_o", mem_ar_addr_o, cur_line);
      if (mem_aw_valid_o && mem_aw_ready_i) wb_addr = mem_aw_addr_o;
      if (mem_w_valid_o && mem_w_ready_i) begin
        check_data("mem_w_data_o", mem_w_data_o, gold_line(wb_addr));
        check_strb("mem_w_strb_o", mem_w_strb_o, 8'hff);
      end
    end
  end

  task automatic read_op(input addr_t a);
    data_t exp;
    exp      = gold_line(a);
    cur_line = {a[31:3], 3'b000};
    @(posedge clk);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= a;
    do @(negedge clk); while (!ar_ready_o);
    @(posedge clk);
    ar_valid_i <= 1'b0;
    do @(negedge clk); while (!r_valid_o);
    check_data("r_data_o", r_data_o, exp);
    check_resp("r_resp_o", r_resp_o, RESP_OKAY);
    repeat ($urandom_range(1, 4)) @(posedge clk);  // core stall
    r_ready_i <= 1'b1;
    @(negedge clk);
    if (!r_valid_o) begin
      n_errors++;
      $display("read response for %h dropped while the core stalled", a);
    end
    check_data("r_data_o", r_data_o, exp);
    @(posedge clk);
    r_ready_i <= 1'b0;
    @(negedge clk);
    if (r_valid_o || b_valid_o) begin
      n_errors++;
      $display("extra response after the read of %h", a);
    end
  endtask

  task automatic write_op(input addr_t a, input data_t d, input strb_t s);
    int   order;
    logic aw_done, w_done, aw_fire, w_fire;
    gold[{a[31:3], 3'b000}] = merge_bytes(gold_line(a), d, s);
    cur_line = {a[31:3], 3'b000};
    order    = $urandom_range(0, 2);  // both, aw first, w first
    aw_done  = 1'b0;
    w_done   = 1'b0;
    @(posedge clk);
    aw_addr_i <= a;
    w_data_i  <= d;
    w_strb_i  <= s;
    if (order != 2) aw_valid_i <= 1'b1;
    if (order != 1) w_valid_i <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk);
      aw_fire = aw_valid_i && aw_ready_o;
      w_fire  = w_valid_i && w_ready_o;
      @(posedge clk);
      if (aw_fire) begin
        aw_valid_i <= 1'b0;
        aw_done = 1'b1;
        if (order == 1) w_valid_i <= 1'b1;
      end
      if (w_fire) begin
        w_valid_i <= 1'b0;
        w_done = 1'b1;
        if (order == 2) aw_valid_i <= 1'b1;
      end
    end
    do @(negedge clk); while (!b_valid_o);
    check_resp("b_resp_o", b_resp_o, RESP_OKAY);
    repeat ($urandom_range(1, 4)) @(posedge clk);
    b_ready_i <= 1'b1;
    @(negedge clk);
    if (!b_valid_o) begin
      n_errors++;
      $display("write response for %h dropped while the core stalled", a);
    end
    @(posedge clk);
    b_ready_i <= 1'b0;
    @(negedge clk);
    if (r_valid_o || b_valid_o) begin
      n_errors++;
      $display("extra response after the write of %h", a);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s: %0d errors", name, n_errors - errs_before);
  endtask

  initial begin
    int    errs;
    addr_t a;
    void'($urandom(32'h5705fe24));
    n_checks   = 0;
    n_errors   = 0;
    rst        = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    cur_line   = '0;
    wb_addr    = '0;
    for (int i = 0; i < POOL; i++) begin
      // four tags on each of sets 5, 17 and 40
      pool[i] = {23'h0a5 + 23'(i / 3) * 23'h13, 6'(i % 3 == 0 ? 5 : (i % 3 == 1 ? 17 : 40)),
                 3'b000};
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    errs = n_errors;
    @(negedge clk);
    check_level("ar_ready_o", ar_ready_o, 1'b1);
    check_level("aw_ready_o", aw_ready_o, 1'b1);
    check_level("r_valid_o", r_valid_o, 1'b0);
    check_level("b_valid_o", b_valid_o, 1'b0);
    check_level("mem_ar_valid_o", mem_ar_valid_o, 1'b0);
    check_level("mem_aw_valid_o", mem_aw_valid_o, 1'b0);
    check_level("mem_w_valid_o", mem_w_valid_o, 1'b0);
    check_level("mem_r_ready_o", mem_r_ready_o, 1'b0);
    check_level("mem_b_ready_o", mem_b_ready_o, 1'b0);
    report_test("reset_state", errs);

    errs = n_errors;
    for (int n = 0; n < NUM_REQS; n++) begin
      a = pool[$urandom_range(0, POOL - 1)] | addr_t'($urandom_range(0, 7));
      if ($urandom_range(0, 1) == 0) read_op(a);
      else write_op(a, {$urandom, $urandom}, strb_t'($urandom_range(1, 255)));
    end
    report_test("random_traffic", errs);

    errs = n_errors;
    for (int i = 0; i < POOL; i++) read_op(pool[i]);
    report_test("readback_sweep", errs);

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, a handshake never completed", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* build.f */
design/dcache_pkg.sv
design/dcache_data_ram.sv
design/dcache_core_port.sv
design/dcache_ctrl.sv
design/dcache_mem_port.sv
design/dcache_top.sv
tests/tb_mem_slave.sv
tests/tb_dcache.sv

/* Makefile */
# Verilator build and run for the dcache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
